// ==== source/tile_loader_pkg.sv ====
package tile_loader_pkg;

    localparam int ELEM_W = 32;
    localparam int BEAT_W = 256;
    localparam int ELEMS_PER_BEAT = 8;    // BEAT_W / ELEM_W
    localparam int DIM_W = 16;

    // Matrix dimensions and global row/column positions
    typedef logic [DIM_W-1:0] dim_t;

    // Addresses count beats, not bytes
    typedef logic [31:0] addr_t;

    typedef logic [BEAT_W-1:0] beat_t;

    typedef enum logic [2:0] {
        IDLE,
        REQ_ROW,     // Issue one row request
        WAIT_ROW,    // Collect beats until dma_last
        DRAIN,       // Last masked beat lands in the buffer
        READY,       // Tile held for the compute array
        DONE
    } seq_state_t;

endpackage

// ==== source/tile_sequencer_fsm.sv ====
`timescale 1ns/1ps

module tile_sequencer_fsm #(
    parameter int TILE = 16,
    localparam int ROW_W = $clog2(TILE)
) (
    input  logic clk,
    input  logic rstn,
    input  logic start,
    input  logic dma_last,
    input  logic row_last,
    input  logic seq_last,
    input  logic tile_consumed,
    output logic dma_start,
    output logic load_b,
    output logic row_step,
    output logic tile_step,
    output logic tile_ready,
    output logic busy,
    output logic done
);

    tile_loader_pkg::seq_state_t state;
    tile_loader_pkg::seq_state_t state_nx;
    logic [ROW_W-1:0] row_seen;    // Rows finished in the current A or B tile
    logic req_open;    // A row request still waits for its dma_last

    always_comb begin
        state_nx = state;
        case (state)
            tile_loader_pkg::IDLE: begin
                if (start) begin
                    state_nx = tile_loader_pkg::REQ_ROW;
                end
            end
            tile_loader_pkg::REQ_ROW: begin
                state_nx = tile_loader_pkg::WAIT_ROW;
            end
            tile_loader_pkg::WAIT_ROW: begin
                if (dma_last) begin
                    if (row_last && load_b) begin
                        state_nx = tile_loader_pkg::DRAIN;
                    end else begin
                        state_nx = tile_loader_pkg::REQ_ROW;
                    end
                end
            end
            tile_loader_pkg::DRAIN: begin
                state_nx = tile_loader_pkg::READY;
            end
            tile_loader_pkg::READY: begin
                if (tile_consumed) begin
                    state_nx = seq_last ? tile_loader_pkg::DONE : tile_loader_pkg::REQ_ROW;
                end
            end
            tile_loader_pkg::DONE: begin
                state_nx = start ? tile_loader_pkg::REQ_ROW : tile_loader_pkg::IDLE;
            end
            default: begin
                state_nx = tile_loader_pkg::IDLE;
            end
        endcase
    end

    assign row_step = (state == tile_loader_pkg::WAIT_ROW) && dma_last;
    assign tile_step = (state == tile_loader_pkg::READY) && tile_consumed;
    assign tile_ready = state == tile_loader_pkg::READY;
    assign busy = (state != tile_loader_pkg::IDLE) && (state != tile_loader_pkg::DONE);
    assign done = state == tile_loader_pkg::DONE;    // DONE lasts a single cycle

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= tile_loader_pkg::IDLE;
            dma_start <= 1'b0;
            load_b <= 1'b0;
            row_seen <= '0;
            req_open <= 1'b0;
        end else begin
            state <= state_nx;
            dma_start <= state_nx == tile_loader_pkg::REQ_ROW;
            if (row_step && row_last) begin
                load_b <= !load_b;    // A then B, back to A for the next step
            end
            if (row_step) begin
                row_seen <= row_last ? '0 : row_seen + 1'b1;
            end
            if (dma_start) begin
                req_open <= 1'b1;
            end else if (dma_last) begin
                req_open <= 1'b0;
            end
        end
    end

    // Only one row request may be outstanding on the memory port
    a_one_request: assert property (@(posedge clk) disable iff (!rstn)
        dma_start |-> !req_open)
        else $error("dma_start while a row request is outstanding");

    // The counter's row_last must agree with the rows this FSM has completed
    a_row_count: assert property (@(posedge clk) disable iff (!rstn)
        row_step && row_last |-> row_seen == ROW_W'(TILE - 1))
        else $error("row_last after %0d rows", row_seen + 1);

endmodule

// ==== source/tile_index_counter.sv ====
`timescale 1ns/1ps

module tile_index_counter #(
    parameter int TILE = 16,
    localparam int ROW_W = $clog2(TILE),
    localparam int BEAT_IW = $clog2(TILE / tile_loader_pkg::ELEMS_PER_BEAT + 1)
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   start,
    input  tile_loader_pkg::dim_t  m,
    input  tile_loader_pkg::dim_t  k,
    input  tile_loader_pkg::dim_t  n,
    input  tile_loader_pkg::addr_t addr_base_a,
    input  tile_loader_pkg::addr_t addr_base_b,
    input  logic                   load_b,
    input  logic                   row_step,
    input  logic                   tile_step,
    input  logic                   dma_valid,
    output tile_loader_pkg::addr_t dma_addr,
    output logic [ROW_W-1:0]       row_idx,
    output logic [BEAT_IW-1:0]     beat_idx,
    output tile_loader_pkg::dim_t  glob_row,
    output tile_loader_pkg::dim_t  glob_col,
    output tile_loader_pkg::dim_t  row_limit,
    output tile_loader_pkg::dim_t  col_limit,
    output logic                   row_last,
    output logic                   seq_last,
    output logic                   k_first,
    output logic                   k_last
);

    localparam int BEATS = TILE / tile_loader_pkg::ELEMS_PER_BEAT;

    tile_loader_pkg::dim_t  m_dim;
    tile_loader_pkg::dim_t  k_dim;
    tile_loader_pkg::dim_t  n_dim;
    tile_loader_pkg::addr_t base_a;
    tile_loader_pkg::addr_t base_b;
    tile_loader_pkg::addr_t pitch_a;
    tile_loader_pkg::addr_t pitch_b;
    tile_loader_pkg::dim_t  m_org;
    tile_loader_pkg::dim_t  n_org;
    tile_loader_pkg::dim_t  k_org;
    tile_loader_pkg::addr_t base_sel;
    tile_loader_pkg::addr_t pitch_sel;
    logic                   m_last;
    logic                   n_last;

    // Pitch is the padded row length in beats
    always_ff @(posedge clk) begin
        if (start) begin
            m_dim <= m;
            k_dim <= k;
            n_dim <= n;
            base_a <= addr_base_a;
            base_b <= addr_base_b;
            pitch_a <= tile_loader_pkg::addr_t'((32'(k) + TILE - 1) / TILE * BEATS);
            pitch_b <= tile_loader_pkg::addr_t'((32'(n) + TILE - 1) / TILE * BEATS);
        end
    end

    assign m_last = 32'(m_org) + TILE >= 32'(m_dim);
    assign n_last = 32'(n_org) + TILE >= 32'(n_dim);
    assign k_last = 32'(k_org) + TILE >= 32'(k_dim);
    assign k_first = k_org == '0;
    assign seq_last = m_last && n_last && k_last;

    // Loop nest is m outer, n middle, k inner
    always_ff @(posedge clk) begin
        if (!rstn) begin
            m_org <= '0;
            n_org <= '0;
            k_org <= '0;
        end else if (start) begin
            m_org <= '0;
            n_org <= '0;
            k_org <= '0;
        end else if (tile_step) begin
            if (!k_last) begin
                k_org <= k_org + tile_loader_pkg::dim_t'(TILE);
            end else begin
                k_org <= '0;
                if (!n_last) begin
                    n_org <= n_org + tile_loader_pkg::dim_t'(TILE);
                end else begin
                    n_org <= '0;
                    m_org <= m_last ? '0 : m_org + tile_loader_pkg::dim_t'(TILE);
                end
            end
        end
    end

    assign row_last = row_idx == ROW_W'(TILE - 1);

    always_ff @(posedge clk) begin
        if (!rstn || start) begin
            row_idx <= '0;
            beat_idx <= '0;
        end else begin
            if (row_step) begin
                row_idx <= row_last ? '0 : row_idx + 1'b1;
                beat_idx <= '0;    // The last beat and row_step share a cycle
            end else if (dma_valid) begin
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

    assign glob_row = (load_b ? k_org : m_org) + tile_loader_pkg::dim_t'(row_idx);
    assign glob_col = load_b ? n_org : k_org;
    assign row_limit = load_b ? k_dim : m_dim;
    assign col_limit = load_b ? n_dim : k_dim;
    assign base_sel = load_b ? base_b : base_a;
    assign pitch_sel = load_b ? pitch_b : pitch_a;

    assign dma_addr = base_sel + tile_loader_pkg::addr_t'(glob_row) * pitch_sel
                    + tile_loader_pkg::addr_t'(glob_col / tile_loader_pkg::ELEMS_PER_BEAT);

    // A request that returns more than one row of beats would overrun the buffer row
    a_beat_in_row: assert property (@(posedge clk) disable iff (!rstn)
        dma_valid |-> beat_idx < BEAT_IW'(BEATS))
        else $error("beat %0d beyond tile row", beat_idx);

endmodule

// ==== source/edge_mask.sv ====
`timescale 1ns/1ps

module edge_mask #(
    parameter int TILE = 16,
    localparam int ROW_W = $clog2(TILE),
    localparam int BEAT_IW = $clog2(TILE / tile_loader_pkg::ELEMS_PER_BEAT + 1),
    localparam int ADDR_W = $clog2(TILE * TILE / tile_loader_pkg::ELEMS_PER_BEAT)
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   dma_valid,
    input  tile_loader_pkg::beat_t dma_data,
    input  logic                   load_b,
    input  logic [ROW_W-1:0]       row_idx,
    input  logic [BEAT_IW-1:0]     beat_idx,
    input  tile_loader_pkg::dim_t  glob_row,
    input  tile_loader_pkg::dim_t  glob_col,
    input  tile_loader_pkg::dim_t  row_limit,
    input  tile_loader_pkg::dim_t  col_limit,
    output logic                   wr_en,
    output logic                   wr_sel,
    output logic [ADDR_W-1:0]      wr_addr,
    output tile_loader_pkg::beat_t wr_data
);

    localparam int BEATS = TILE / tile_loader_pkg::ELEMS_PER_BEAT;
    localparam int COL_W = tile_loader_pkg::DIM_W + 1;    // Room for the carry past n or k

    tile_loader_pkg::beat_t masked;
    logic [COL_W-1:0]       beat_col;
    logic [COL_W-1:0]       elem_col;
    logic                   row_ok;

    always_comb begin
        beat_col = COL_W'(glob_col) + COL_W'(beat_idx) * COL_W'(tile_loader_pkg::ELEMS_PER_BEAT);
        row_ok = glob_row < row_limit;    // Padding rows of the tile fail here
        elem_col = beat_col;
        for (int e = 0; e < tile_loader_pkg::ELEMS_PER_BEAT; e++) begin
            elem_col = beat_col + COL_W'(e);
            masked[e*tile_loader_pkg::ELEM_W +: tile_loader_pkg::ELEM_W] =
                (row_ok && elem_col < COL_W'(col_limit)) ?
                dma_data[e*tile_loader_pkg::ELEM_W +: tile_loader_pkg::ELEM_W] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= dma_valid;
        end
    end

    always_ff @(posedge clk) begin
        wr_sel <= load_b;
        wr_addr <= ADDR_W'(row_idx) * ADDR_W'(BEATS) + ADDR_W'(beat_idx);
        wr_data <= masked;
    end

endmodule

// ==== source/tile_buffer.sv ====
`timescale 1ns/1ps

module tile_buffer #(
    parameter int TILE = 16,
    localparam int DEPTH = TILE * TILE / tile_loader_pkg::ELEMS_PER_BEAT,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic                   clk,
    input  logic                   wr_en,
    input  logic                   wr_sel,
    input  logic [ADDR_W-1:0]      wr_addr,
    input  tile_loader_pkg::beat_t wr_data,
    input  logic                   rd_sel,
    input  logic [ADDR_W-1:0]      rd_addr,
    output tile_loader_pkg::beat_t rd_data
);

    // Row r of a tile occupies entries r*TILE/8 up to r*TILE/8 + TILE/8 - 1
    tile_loader_pkg::beat_t mem_a [DEPTH];
    tile_loader_pkg::beat_t mem_b [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en && !wr_sel) begin
            mem_a[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && wr_sel) begin
            mem_b[wr_addr] <= wr_data;
        end
    end

    // Read data appears the cycle after rd_addr
    always_ff @(posedge clk) begin
        if (rd_sel) begin
            rd_data <= mem_b[rd_addr];
        end else begin
            rd_data <= mem_a[rd_addr];
        end
    end

    a_wr_in_range: assert property (@(posedge clk)
        wr_en |-> 32'(wr_addr) < DEPTH)
        else $error("buffer write at %0d past depth %0d", wr_addr, DEPTH);

endmodule

// ==== source/tile_loader_top.sv ====
`timescale 1ns/1ps

module tile_loader_top #(
    parameter int TILE = 16,
    localparam int ROW_W = $clog2(TILE),
    localparam int BEAT_IW = $clog2(TILE / tile_loader_pkg::ELEMS_PER_BEAT + 1),
    localparam int ADDR_W = $clog2(TILE * TILE / tile_loader_pkg::ELEMS_PER_BEAT)
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   start,
    input  tile_loader_pkg::dim_t  m,
    input  tile_loader_pkg::dim_t  k,
    input  tile_loader_pkg::dim_t  n,
    input  tile_loader_pkg::addr_t addr_base_a,
    input  tile_loader_pkg::addr_t addr_base_b,
    output logic                   dma_start,
    output tile_loader_pkg::addr_t dma_addr,
    input  logic                   dma_valid,
    input  tile_loader_pkg::beat_t dma_data,
    input  logic                   dma_last,
    output logic                   tile_ready,
    output logic                   k_first,
    output logic                   k_last,
    input  logic                   tile_consumed,
    input  logic                   rd_sel,
    input  logic [ADDR_W-1:0]      rd_addr,
    output tile_loader_pkg::beat_t rd_data,
    output logic                   busy,
    output logic                   done
);

    logic                   load_b;
    logic                   row_step;
    logic                   tile_step;
    logic                   row_last;
    logic                   seq_last;
    logic [ROW_W-1:0]       row_idx;
    logic [BEAT_IW-1:0]     beat_idx;
    tile_loader_pkg::dim_t  glob_row;
    tile_loader_pkg::dim_t  glob_col;
    tile_loader_pkg::dim_t  row_limit;
    tile_loader_pkg::dim_t  col_limit;
    logic                   wr_en;
    logic                   wr_sel;
    logic [ADDR_W-1:0]      wr_addr;
    tile_loader_pkg::beat_t wr_data;

    tile_sequencer_fsm #(.TILE(TILE)) tile_sequencer_fsm_i (
        .clk(clk), .rstn(rstn), .start(start), .dma_last(dma_last),
        .row_last(row_last), .seq_last(seq_last), .tile_consumed(tile_consumed),
        .dma_start(dma_start), .load_b(load_b), .row_step(row_step),
        .tile_step(tile_step), .tile_ready(tile_ready), .busy(busy), .done(done)
    );

    // busy is low exactly in the states that accept start
    tile_index_counter #(.TILE(TILE)) tile_index_counter_i (
        .clk(clk), .rstn(rstn), .start(start && !busy), .m(m), .k(k), .n(n),
        .addr_base_a(addr_base_a), .addr_base_b(addr_base_b), .load_b(load_b),
        .row_step(row_step), .tile_step(tile_step), .dma_valid(dma_valid),
        .dma_addr(dma_addr), .row_idx(row_idx), .beat_idx(beat_idx),
        .glob_row(glob_row), .glob_col(glob_col), .row_limit(row_limit),
        .col_limit(col_limit), .row_last(row_last), .seq_last(seq_last),
        .k_first(k_first), .k_last(k_last)
    );

    edge_mask #(.TILE(TILE)) edge_mask_i (
        .clk(clk), .rstn(rstn), .dma_valid(dma_valid), .dma_data(dma_data),
        .load_b(load_b), .row_idx(row_idx), .beat_idx(beat_idx),
        .glob_row(glob_row), .glob_col(glob_col), .row_limit(row_limit),
        .col_limit(col_limit), .wr_en(wr_en), .wr_sel(wr_sel),
        .wr_addr(wr_addr), .wr_data(wr_data)
    );

    tile_buffer #(.TILE(TILE)) tile_buffer_i (
        .clk(clk), .wr_en(wr_en), .wr_sel(wr_sel), .wr_addr(wr_addr),
        .wr_data(wr_data), .rd_sel(rd_sel), .rd_addr(rd_addr), .rd_data(rd_data)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;    // 100 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

// ==== verification/tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model #(
    parameter int TILE = 16
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   dma_start,
    input  tile_loader_pkg::addr_t dma_addr,
    output logic                   dma_valid,
    output tile_loader_pkg::beat_t dma_data,
    output logic                   dma_last
);

    localparam int BEATS = TILE / tile_loader_pkg::ELEMS_PER_BEAT;

    integer seed = 32'he0d;
    logic valid_q = 1'b0;
    logic last_q = 1'b0;
    tile_loader_pkg::beat_t data_q = '0;
    tile_loader_pkg::addr_t req_addr;
    tile_loader_pkg::addr_t beat_addr;
    logic pending;
    int beat;
    int gap;

    assign dma_valid = valid_q;
    assign dma_last = last_q;
    assign dma_data = data_q;

    // Each element holds the low 24 address bits and its own index
    always @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
            last_q <= 1'b0;
            pending <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            last_q <= 1'b0;
            if (dma_start) begin
                req_addr <= dma_addr;
                beat <= 0;
                gap <= $random(seed) & 3;
                pending <= 1'b1;
            end else if (pending && gap > 0) begin
                gap <= gap - 1;
            end else if (pending) begin
                beat_addr = req_addr + 32'(beat);
                for (int e = 0; e < tile_loader_pkg::ELEMS_PER_BEAT; e++) begin
                    data_q[e*32 +: 32] <= {beat_addr[23:0], 8'(e)};
                end
                valid_q <= 1'b1;
                last_q <= beat == BEATS - 1;
                pending <= beat != BEATS - 1;
                beat <= beat + 1;
                gap <= $random(seed) & 3;    // Random gap before the next beat
            end
        end
    end

endmodule

// ==== verification/tile_loader_tb.sv ====
`timescale 1ns/1ps

module tile_loader_tb;

    localparam int TILE = 16;
    localparam int EPB = tile_loader_pkg::ELEMS_PER_BEAT;
    localparam int BEATS = TILE / EPB;
    localparam int DEPTH = TILE * BEATS;
    localparam int ADDR_W = $clog2(DEPTH);
    localparam int TIMEOUT = 2000;

    logic clk;
    logic rstn;
    logic start = 1'b0;
    tile_loader_pkg::dim_t m = '0;
    tile_loader_pkg::dim_t k = '0;
    tile_loader_pkg::dim_t n = '0;
    tile_loader_pkg::addr_t addr_base_a = '0;
    tile_loader_pkg::addr_t addr_base_b = '0;
    logic dma_start;
    tile_loader_pkg::addr_t dma_addr;
    logic dma_valid;
    tile_loader_pkg::beat_t dma_data;
    logic dma_last;
    logic tile_ready;
    logic k_first;
    logic k_last;
    logic tile_consumed = 1'b0;
    logic rd_sel = 1'b0;
    logic [ADDR_W-1:0] rd_addr = '0;
    tile_loader_pkg::beat_t rd_data;
    logic busy;
    logic done;

    logic rd_chk = 1'b0;
    logic chk_d = 1'b0;
    logic full_chk = 1'b0;
    logic sel_d;
    logic [ADDR_W-1:0] addr_d;
    tile_loader_pkg::beat_t rd_exp;
    tile_loader_pkg::beat_t exp_d;
    logic exp_kf = 1'b0;
    logic exp_kl = 1'b0;
    logic final_sent = 1'b0;
    logic in_run = 1'b0;
    int tiles_seen = 0;
    int tiles_expected = 0;
    int data_errs = 0;
    int ctrl_errs = 0;
    int timeouts = 0;
    integer seed = 32'he0d;
    int cur_m;
    int cur_k;
    int cur_n;
    logic [31:0] cur_ba;
    logic [31:0] cur_bb;

    tb_clock_gen tb_clock_gen_i (.*);
    tb_mem_model #(.TILE(TILE)) tb_mem_model_i (.*);
    tile_loader_top #(.TILE(TILE)) tile_loader_top_i (.*);

    // rd_data lags rd_addr by one cycle
    always @(posedge clk) begin
        chk_d <= rd_chk;
        exp_d <= rd_exp;
        sel_d <= rd_sel;
        addr_d <= rd_addr;
    end

    function automatic tile_loader_pkg::beat_t expected_beat(input logic sel, input int a,
                                                             input int mo, input int no,
                                                             input int ko);
        tile_loader_pkg::beat_t b;
        int grow;
        int gcol;
        int pitch;
        int col;
        logic [31:0] addr;
        grow = (sel ? ko : mo) + a / BEATS;
        gcol = sel ? no : ko;
        pitch = ((sel ? cur_n : cur_k) + TILE - 1) / TILE * BEATS;
        addr = (sel ? cur_bb : cur_ba) + 32'(grow * pitch + gcol / EPB + a % BEATS);
        for (int e = 0; e < EPB; e++) begin
            col = gcol + (a % BEATS) * EPB + e;
            if (grow < (sel ? cur_k : cur_m) && col < (sel ? cur_n : cur_k)) begin
                b[e*32 +: 32] = {addr[23:0], 8'(e)};
            end else begin
                b[e*32 +: 32] = 32'h0;
            end
        end
        return b;
    endfunction

    function automatic logic has_zero_elem(input tile_loader_pkg::beat_t b);
        logic z;
        z = 1'b0;
        for (int e = 0; e < EPB; e++) begin
            z = z | (b[e*32 +: 32] == 32'h0);
        end
        return z;
    endfunction

    a_reset_low: assert property (@(posedge clk)
        $rose(rstn) |-> !(dma_start || tile_ready || busy || done))
        else begin
            ctrl_errs++;
            $display("Outputs were not all low after reset");
        end

    a_rd_data: assert property (@(posedge clk) disable iff (!rstn) chk_d |-> rd_data == exp_d)
        else begin
            data_errs++;
            $display("ERR rd_data sel=%0h addr=%0h got=%h exp=%h", $sampled(sel_d),
                     $sampled(addr_d), $sampled(rd_data), $sampled(exp_d));
        end

    a_no_zero: assert property (@(posedge clk) disable iff (!rstn)
        chk_d && full_chk |-> !has_zero_elem(rd_data))
        else begin
            data_errs++;
            $display("ERR rd_data zero element sel=%0h addr=%0h got=%h", $sampled(sel_d),
                     $sampled(addr_d), $sampled(rd_data));
        end

    a_k_first: assert property (@(posedge clk) disable iff (!rstn)
        tile_ready && in_run |-> k_first == exp_kf)
        else begin
            ctrl_errs++;
            $display("ERR k_first got=%h exp=%h", $sampled(k_first), $sampled(exp_kf));
        end

    a_k_last: assert property (@(posedge clk) disable iff (!rstn)
        tile_ready && in_run |-> k_last == exp_kl)
        else begin
            ctrl_errs++;
            $display("ERR k_last got=%h exp=%h", $sampled(k_last), $sampled(exp_kl));
        end

    a_no_req_when_ready: assert property (@(posedge clk) disable iff (!rstn)
        !(dma_start && tile_ready))
        else begin
            ctrl_errs++;
            $display("A row request was issued while a tile was held");
        end

    a_start_req: assert property (@(posedge clk) disable iff (!rstn)
        start && !busy |=> dma_start && busy)
        else begin
            ctrl_errs++;
            $display("No row request and busy in the cycle after start");
        end

    a_done_final: assert property (@(posedge clk) disable iff (!rstn)
        done |-> final_sent && tiles_seen == tiles_expected)
        else begin
            ctrl_errs++;
            $display("ERR tiles_seen got=%h exp=%h at done", $sampled(tiles_seen),
                     $sampled(tiles_expected));
        end

    a_done_once: assert property (@(posedge clk) disable iff (!rstn) done |=> !done)
        else begin
            ctrl_errs++;
            $display("done stayed high for more than one cycle");
        end

    a_read_when_ready: assert property (@(posedge clk) disable iff (!rstn) rd_chk |-> tile_ready)
        else begin
            ctrl_errs++;
            $display("Tile buffer was read while no tile was ready");
        end

    // which selects the signal to wait for: 0 tile_ready, 1 done, 2 rstn
    task automatic await_signal(input int which, input string what, output bit ok);
        ok = 1'b0;
        for (int t = 0; t < TIMEOUT && !ok; t++) begin
            @(posedge clk);
            ok = (which == 0) ? tile_ready : (which == 1) ? done : rstn;
        end
        if (!ok) begin
            timeouts++;
            $display("Timeout while waiting for %s after %0d cycles", what, TIMEOUT);
        end
    endtask

    task automatic run_matrix(input int mm, input int kk, input int nn,
                              input logic [31:0] ba, input logic [31:0] bb, input logic full);
        int mt_n;
        int nt_n;
        int kt_n;
        int delay;
        bit ok;
        cur_m = mm;
        cur_k = kk;
        cur_n = nn;
        cur_ba = ba;
        cur_bb = bb;
        mt_n = (mm + TILE - 1) / TILE;
        nt_n = (nn + TILE - 1) / TILE;
        kt_n = (kk + TILE - 1) / TILE;
        @(posedge clk);
        m <= tile_loader_pkg::dim_t'(mm);
        k <= tile_loader_pkg::dim_t'(kk);
        n <= tile_loader_pkg::dim_t'(nn);
        addr_base_a <= ba;
        addr_base_b <= bb;
        start <= 1'b1;
        full_chk <= full;
        tiles_seen <= 0;
        tiles_expected <= mt_n * nt_n * kt_n;
        final_sent <= 1'b0;
        in_run <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        for (int mt = 0; mt < mt_n; mt++) begin
            for (int nt = 0; nt < nt_n; nt++) begin
                for (int kt = 0; kt < kt_n; kt++) begin
                    exp_kf <= kt == 0;
                    exp_kl <= kt == kt_n - 1;
                    await_signal(0, "tile_ready", ok);
                    if (!ok) begin
                        return;
                    end
                    tiles_seen <= tiles_seen + 1;
                    for (int s = 0; s < 2; s++) begin
                        for (int a = 0; a < DEPTH; a++) begin
                            rd_sel <= s[0];
                            rd_addr <= ADDR_W'(a);
                            rd_chk <= 1'b1;
                            rd_exp <= expected_beat(s[0], a, mt * TILE, nt * TILE, kt * TILE);
                            @(posedge clk);
                        end
                    end
                    rd_chk <= 1'b0;
                    delay = $random(seed) & 15;    // Compute array holds the tile a while
                    repeat (delay) @(posedge clk);
                    tile_consumed <= 1'b1;
                    final_sent <= mt == mt_n - 1 && nt == nt_n - 1 && kt == kt_n - 1;
                    @(posedge clk);
                    tile_consumed <= 1'b0;
                end
            end
        end
        await_signal(1, "done", ok);
        in_run <= 1'b0;
    endtask

    initial begin
        bit ok;
        await_signal(2, "reset release", ok);
        if (ok) begin
            run_matrix(32, 32, 32, 32'h0000_1000, 32'h0000_8000, 1'b1);
        end
        if (timeouts == 0) begin
            run_matrix(20, 13, 27, 32'h0002_0000, 32'h0003_0400, 1'b0);
        end
        if (timeouts == 0) begin
            run_matrix(40, 24, 9, 32'h0004_5600, 32'h0006_0000, 1'b0);    // New bases after done
        end
        repeat (4) @(posedge clk);
        $display("Errors: data %0d, control %0d, timeouts %0d", data_errs, ctrl_errs, timeouts);
        if (data_errs + ctrl_errs + timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== project.f ====
source/tile_loader_pkg.sv
source/tile_sequencer_fsm.sv
source/tile_index_counter.sv
source/edge_mask.sv
source/tile_buffer.sv
source/tile_loader_top.sv
verification/tb_clock_gen.sv
verification/tb_mem_model.sv
verification/tile_loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tile_loader_tb \
    -f project.f -o tile_loader_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tile_loader_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'All tests passed!'; then
    exit 0
fi
exit 1
